// File: hdl/dma_pkg.sv
// ##########################################################################
// Shared widths, register map and types of the DMA copy engine
// All addresses and counts are in 32-bit words, there is no byte access
// The widths are fixed; the blocks are not meant to be resized
// ##########################################################################

package dma_pkg;

  // Widths
  localparam int AddrWidth    = 32;
  localparam int DataWidth    = 32;
  localparam int CountWidth   = 16;
  localparam int IdWidth      = 8;
  localparam int RegAddrWidth = 3;

  // Descriptor buffer depth
  localparam int FifoDepth = 2;

  typedef logic [AddrWidth-1:0]    addr_t;
  typedef logic [DataWidth-1:0]    data_t;
  typedef logic [CountWidth-1:0]   count_t;
  typedef logic [IdWidth-1:0]      id_t;
  typedef logic [RegAddrWidth-1:0] reg_addr_t;

  // Register map, word indices
  localparam reg_addr_t RegSrc    = 3'd0;
  localparam reg_addr_t RegDst    = 3'd1;
  localparam reg_addr_t RegCount  = 3'd2;
  localparam reg_addr_t RegNextId = 3'd3;
  localparam reg_addr_t RegDoneId = 3'd4;
  localparam reg_addr_t RegStatus = 3'd5;

  // One copy job as handed from the frontend to the backend
  typedef struct packed {
    id_t    id;
    addr_t  src;
    addr_t  dst;
    count_t count;
  } dma_desc_t;

  typedef struct packed {
    logic      valid;
    logic      write;
    reg_addr_t addr;
    data_t     wdata;
  } reg_req_t;

  typedef struct packed {
    logic  rvalid;
    data_t rdata;
  } reg_rsp_t;

  typedef struct packed {
    logic  valid;
    addr_t addr;
  } mem_rd_t;

  typedef struct packed {
    logic  valid;
    addr_t addr;
    data_t data;
  } mem_wr_t;

  typedef enum logic [1:0] {
    st_idle,
    st_copy,
    st_drain
  } copy_state_t;

endpackage

// File: hdl/dma_reg_frontend.sv
// ##########################################################################
// Register frontend of the DMA engine
// Requests are never stalled; each read is answered one cycle later
// A NEXT_ID read launches the programmed job and returns its id, or 0
// when the descriptor buffer is full and the launch is refused
// Ids count from 1 upward and skip 0 on wrap
// ##########################################################################

`timescale 1ns/1ns

module dma_reg_frontend (
  input  logic                clk_i,
  input  logic                rst_i,
  input  dma_pkg::reg_req_t   reg_req_i,
  output dma_pkg::reg_rsp_t   reg_rsp_o,
  output dma_pkg::dma_desc_t  desc_o,
  output logic                desc_valid_o,
  input  logic                desc_ready_i,
  input  logic                trans_complete_i
);

  import dma_pkg::*;

  // Next id after a given one, 0 is reserved for a refused launch
  function automatic id_t id_incr(input id_t id);
    id_t nxt;
    nxt = id + 1'b1;
    if (nxt == '0) begin
      nxt = id_t'(1);
    end
    return nxt;
  endfunction

  addr_t  src_q;
  addr_t  dst_q;
  count_t count_q;
  id_t    issued_id_q;
  id_t    done_id_q;
  id_t    next_id;
  logic   busy;
  logic   rd_req;
  logic   wr_req;
  logic   launch;
  logic   rvalid_q;
  data_t  rdata_q;
  data_t  rdata_d;

  assign rd_req  = reg_req_i.valid && !reg_req_i.write;
  assign wr_req  = reg_req_i.valid && reg_req_i.write;
  assign launch  = rd_req && (reg_req_i.addr == RegNextId);
  assign next_id = id_incr(issued_id_q);

  // Jobs finish in launch order, so one counter per side is enough
  assign busy = (done_id_q != issued_id_q);

  assign desc_valid_o = launch;

  always_comb begin
    desc_o.id    = next_id;
    desc_o.src   = src_q;
    desc_o.dst   = dst_q;
    desc_o.count = count_q;
  end

  // Read data is sampled in the request cycle
  always_comb begin
    rdata_d = '0;
    case (reg_req_i.addr)
      RegSrc:    rdata_d = src_q;
      RegDst:    rdata_d = dst_q;
      RegCount:  rdata_d = data_t'(count_q);
      RegNextId: begin
        if (desc_ready_i) begin
          rdata_d = data_t'(next_id);
        end
      end
      RegDoneId: rdata_d = data_t'(done_id_q);
      RegStatus: rdata_d = data_t'(busy);
      default:   rdata_d = '0;
    endcase
  end

  // Software registers
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      src_q   <= '0;
      dst_q   <= '0;
      count_q <= '0;
    end else if (wr_req) begin
      case (reg_req_i.addr)
        RegSrc:   src_q   <= reg_req_i.wdata;
        RegDst:   dst_q   <= reg_req_i.wdata;
        RegCount: count_q <= reg_req_i.wdata[CountWidth-1:0];
        default:  ;
      endcase
    end
  end

  // Id tracking
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      issued_id_q <= '0;
      done_id_q   <= '0;
    end else begin
      if (launch && desc_ready_i) begin
        issued_id_q <= next_id;
      end
      if (trans_complete_i) begin
        done_id_q <= id_incr(done_id_q);
      end
    end
  end

  // Read response
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= rd_req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_req) begin
      rdata_q <= rdata_d;
    end
  end

  always_comb begin
    reg_rsp_o.rvalid = rvalid_q;
    reg_rsp_o.rdata  = rdata_q;
  end

endmodule

// File: hdl/dma_desc_fifo.sv
// ##########################################################################
// Descriptor buffer between frontend and backend, FifoDepth entries
// Ready stays high when full if the head is popped in the same cycle
// Delivery is strictly in order
// ##########################################################################

`timescale 1ns/1ns

module dma_desc_fifo (
  input  logic                clk_i,
  input  logic                rst_i,
  input  dma_pkg::dma_desc_t  in_desc_i,
  input  logic                in_valid_i,
  output logic                in_ready_o,
  output dma_pkg::dma_desc_t  out_desc_o,
  output logic                out_valid_o,
  input  logic                out_ready_i
);

  import dma_pkg::*;

  typedef logic [$clog2(FifoDepth)-1:0]   ptr_t;
  typedef logic [$clog2(FifoDepth+1)-1:0] cnt_t;

  function automatic ptr_t ptr_incr(input ptr_t ptr);
    if (ptr == ptr_t'(FifoDepth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  dma_desc_t mem_q [FifoDepth];
  ptr_t      wr_ptr_q;
  ptr_t      rd_ptr_q;
  cnt_t      count_q;
  logic      full;
  logic      push;
  logic      pop;

  assign full        = (count_q == cnt_t'(FifoDepth));
  assign out_valid_o = (count_q != '0);
  assign in_ready_o  = !full || out_ready_i;
  assign out_desc_o  = mem_q[rd_ptr_q];

  assign push = in_valid_i && in_ready_o;
  assign pop  = out_valid_o && out_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_incr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_incr(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_desc_i;
    end
  end

endmodule

// File: hdl/dma_copy_backend.sv
// ##########################################################################
// Word copy backend of the DMA engine
// Assumes the memory never stalls and returns read data one cycle after
// the read strobe; one read is issued per cycle
// A write follows its read by two cycles; completion pulses one cycle
// after the last write, or one cycle after the pop for a zero count
// ##########################################################################

`timescale 1ns/1ns

module dma_copy_backend (
  input  logic                clk_i,
  input  logic                rst_i,
  input  dma_pkg::dma_desc_t  desc_i,
  input  logic                desc_valid_i,
  output logic                desc_ready_o,
  output dma_pkg::mem_rd_t    mem_rd_o,
  input  dma_pkg::data_t      mem_rdata_i,
  output dma_pkg::mem_wr_t    mem_wr_o,
  output logic                trans_complete_o
);

  import dma_pkg::*;

  copy_state_t state_q;
  copy_state_t state_d;
  addr_t       rd_addr_q;
  count_t      rd_left_q;
  addr_t       wr_addr_q;
  data_t       wr_data_q;
  logic        rd_valid_q;
  logic        wr_valid_q;
  logic        pop;
  logic        rd_issue;
  logic        pipe_empty;

  // A new job is only taken once the previous one has fully drained
  assign desc_ready_o = (state_q == st_idle);
  assign pop          = desc_valid_i && desc_ready_o;
  assign rd_issue     = (state_q == st_copy);
  assign pipe_empty   = !rd_valid_q && !wr_valid_q;

  assign trans_complete_o = (state_q == st_drain) && pipe_empty;

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (desc_valid_i) begin
          state_d = (desc_i.count == '0) ? st_drain : st_copy;
        end
      end
      st_copy: begin
        // Last read goes out this cycle
        if (rd_left_q == count_t'(1)) begin
          state_d = st_drain;
        end
      end
      st_drain: begin
        if (pipe_empty) begin
          state_d = st_idle;
        end
      end
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q    <= st_idle;
      rd_valid_q <= 1'b0;
      wr_valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // Stage 1 marks the cycle where read data returns
      rd_valid_q <= rd_issue;
      // Stage 2 holds the word for its write
      wr_valid_q <= rd_valid_q;
    end
  end

  // Read side counters
  always_ff @(posedge clk_i) begin
    if (pop) begin
      rd_addr_q <= desc_i.src;
      rd_left_q <= desc_i.count;
    end else if (rd_issue) begin
      rd_addr_q <= rd_addr_q + 1'b1;
      rd_left_q <= rd_left_q - 1'b1;
    end
  end

  // Write side address and data
  always_ff @(posedge clk_i) begin
    if (pop) begin
      wr_addr_q <= desc_i.dst;
    end else if (wr_valid_q) begin
      wr_addr_q <= wr_addr_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_valid_q) begin
      wr_data_q <= mem_rdata_i;
    end
  end

  always_comb begin
    mem_rd_o.valid = rd_issue;
    mem_rd_o.addr  = rd_addr_q;
    mem_wr_o.valid = wr_valid_q;
    mem_wr_o.addr  = wr_addr_q;
    mem_wr_o.data  = wr_data_q;
  end

endmodule

// File: hdl/dma_core.sv
// ##########################################################################
// DMA copy engine top level
// Register port in, plain word memory port out
// The memory must accept every access and answer reads one cycle later
// ##########################################################################

`timescale 1ns/1ns

module dma_core (
  input  logic               clk_i,
  input  logic               rst_i,
  input  dma_pkg::reg_req_t  reg_req_i,
  output dma_pkg::reg_rsp_t  reg_rsp_o,
  output dma_pkg::mem_rd_t   mem_rd_o,
  input  dma_pkg::data_t     mem_rdata_i,
  output dma_pkg::mem_wr_t   mem_wr_o
);

  import dma_pkg::*;

  dma_desc_t fe_desc;
  logic      fe_valid;
  logic      fe_ready;
  dma_desc_t be_desc;
  logic      be_valid;
  logic      be_ready;
  logic      be_trans_complete;

  dma_reg_frontend i_frontend (
    .clk_i            ( clk_i             ),
    .rst_i            ( rst_i             ),
    .reg_req_i        ( reg_req_i         ),
    .reg_rsp_o        ( reg_rsp_o         ),
    .desc_o           ( fe_desc           ),
    .desc_valid_o     ( fe_valid          ),
    .desc_ready_i     ( fe_ready          ),
    .trans_complete_i ( be_trans_complete )
  );

  // Lets software queue a job while the backend is still copying
  dma_desc_fifo i_desc_fifo (
    .clk_i       ( clk_i    ),
    .rst_i       ( rst_i    ),
    .in_desc_i   ( fe_desc  ),
    .in_valid_i  ( fe_valid ),
    .in_ready_o  ( fe_ready ),
    .out_desc_o  ( be_desc  ),
    .out_valid_o ( be_valid ),
    .out_ready_i ( be_ready )
  );

  dma_copy_backend i_backend (
    .clk_i            ( clk_i             ),
    .rst_i            ( rst_i             ),
    .desc_i           ( be_desc           ),
    .desc_valid_i     ( be_valid          ),
    .desc_ready_o     ( be_ready          ),
    .mem_rd_o         ( mem_rd_o          ),
    .mem_rdata_i      ( mem_rdata_i       ),
    .mem_wr_o         ( mem_wr_o          ),
    .trans_complete_o ( be_trans_complete )
  );

endmodule

// File: verification/dma_core_props.sv
// ##########################################################################
// Handshake and strobe assertions, bound into every copy backend
// Nothing is checked while reset is high
// ##########################################################################

`timescale 1ns/1ns

module dma_core_props (
  input logic             clk_i,
  input logic             rst_i,
  input logic             desc_ready_i,
  input dma_pkg::mem_rd_t mem_rd_i,
  input dma_pkg::mem_wr_t mem_wr_i,
  input logic             trans_complete_i
);

  // No job is taken while reads are still going out
  ready_during_read: assert property (@(posedge clk_i) disable iff (rst_i)
    !(desc_ready_i && mem_rd_i.valid))
    else $error("Backend ready while a read is issued");

  complete_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    trans_complete_i |=> !trans_complete_i)
    else $error("Completion held high for more than one cycle");

  read_to_write: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_rd_i.valid |-> ##2 mem_wr_i.valid)
    else $error("Read not followed by a write two cycles later");

  write_from_read: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_wr_i.valid |-> $past(mem_rd_i.valid, 2))
    else $error("Write without a read two cycles before");

endmodule

bind dma_copy_backend dma_core_props i_props (
  .clk_i            ( clk_i            ),
  .rst_i            ( rst_i            ),
  .desc_ready_i     ( desc_ready_o     ),
  .mem_rd_i         ( mem_rd_o         ),
  .mem_wr_i         ( mem_wr_o         ),
  .trans_complete_i ( trans_complete_o )
);

// File: verification/dma_core_checker.sv
// ##########################################################################
// Reference model and scoreboard for the DMA copy engine ports
// Samples everything on the rising edge and expects one request per cycle
// Memory words are expected to read as their address XOR FillKey
// ##########################################################################

`timescale 1ns/1ns

module dma_core_checker #(
  parameter dma_pkg::data_t FillKey = '0
) (
  input  logic               clk_i,
  input  logic               rst_i,
  input  dma_pkg::reg_req_t  reg_req_i,
  input  dma_pkg::reg_rsp_t  reg_rsp_i,
  input  dma_pkg::mem_rd_t   mem_rd_i,
  input  dma_pkg::mem_wr_t   mem_wr_i,
  input  logic               final_i,
  output int                 errors_o
);

  import dma_pkg::*;

  addr_t     src_sh;
  addr_t     dst_sh;
  count_t    count_sh;
  logic      rd_pend;
  reg_addr_t rd_pend_addr;
  data_t     rd_pend_val;
  id_t       last_id;
  logic      idle_seen;
  logic      final_done;
  logic      launch_ok;
  int        be_busy;
  int        err_count = 0;
  int        wr_count;
  int        count_sum;
  count_t    pend_cnt_q[$];
  addr_t     rd_exp_q[$];
  addr_t     wr_addr_q[$];
  data_t     wr_data_q[$];

  assign errors_o = err_count;

  task automatic report_mismatch(input string name, input data_t got, input data_t exp);
    $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    err_count++;
  endtask

  task automatic report_failure(input string what);
    $display("Error at %0t ns: %s", $time, what);
    err_count++;
  endtask

  // Expected reads and writes of one accepted job
  task automatic queue_job(input dma_desc_t d);
    for (int k = 0; k < int'(d.count); k++) begin
      rd_exp_q.push_back(d.src + addr_t'(k));
      wr_addr_q.push_back(d.dst + addr_t'(k));
      wr_data_q.push_back((d.src + addr_t'(k)) ^ FillKey);
    end
    count_sum += int'(d.count);
  endtask

  // Buffer and backend occupancy as seen before this edge
  task automatic advance_model();
    count_t head;
    launch_ok = (pend_cnt_q.size() < FifoDepth) || (be_busy == 0);
    if (be_busy == 0 && pend_cnt_q.size() != 0) begin
      head = pend_cnt_q.pop_front();
      // Reads, two pipeline stages and the completion cycle
      be_busy = (head == '0) ? 1 : int'(head) + 3;
    end else if (be_busy > 0) begin
      be_busy--;
    end
  endtask

  task automatic check_response();
    if (reg_rsp_i.rvalid !== rd_pend) begin
      report_failure("read response valid is not one cycle after a read request");
    end else if (rd_pend) begin
      case (rd_pend_addr)
        RegSrc, RegDst, RegCount, RegNextId: begin
          if (reg_rsp_i.rdata !== rd_pend_val) begin
            report_mismatch("reg_rsp_o.rdata", reg_rsp_i.rdata, rd_pend_val);
          end
        end
        RegDoneId: begin
          if (idle_seen && reg_rsp_i.rdata !== data_t'(last_id)) begin
            report_mismatch("DONE_ID rdata", reg_rsp_i.rdata, data_t'(last_id));
          end
        end
        RegStatus: begin
          if (reg_rsp_i.rdata[0] === 1'b0) begin
            idle_seen = 1'b1;
            if (rd_exp_q.size() != 0 || wr_addr_q.size() != 0) begin
              report_failure("STATUS shows idle while words are still to be copied");
            end
          end
        end
        default: ;
      endcase
    end
  endtask

  task automatic track_request();
    id_t       exp_id;
    dma_desc_t job;
    rd_pend = 1'b0;
    if (reg_req_i.valid && reg_req_i.write) begin
      case (reg_req_i.addr)
        RegSrc:   src_sh   = reg_req_i.wdata;
        RegDst:   dst_sh   = reg_req_i.wdata;
        RegCount: count_sh = reg_req_i.wdata[CountWidth-1:0];
        default:  ;
      endcase
    end else if (reg_req_i.valid) begin
      rd_pend      = 1'b1;
      rd_pend_addr = reg_req_i.addr;
      case (reg_req_i.addr)
        RegSrc:   rd_pend_val = src_sh;
        RegDst:   rd_pend_val = dst_sh;
        RegCount: rd_pend_val = data_t'(count_sh);
        default:  rd_pend_val = '0;
      endcase
      // A launch is refused only while the buffer is full and the backend busy
      if (reg_req_i.addr == RegNextId && launch_ok) begin
        exp_id = last_id + 1'b1;
        if (exp_id == '0) begin
          exp_id = id_t'(1);
        end
        job         = '{id: exp_id, src: src_sh, dst: dst_sh, count: count_sh};
        last_id     = exp_id;
        idle_seen   = 1'b0;
        rd_pend_val = data_t'(exp_id);
        queue_job(job);
        pend_cnt_q.push_back(count_sh);
      end
    end
  endtask

  always @(posedge clk_i) begin
    addr_t exp_addr;
    data_t exp_data;
    if (rst_i) begin
      src_sh     = '0;
      dst_sh     = '0;
      count_sh   = '0;
      rd_pend    = 1'b0;
      last_id    = '0;
      idle_seen  = 1'b0;
      final_done = 1'b0;
      be_busy    = 0;
      wr_count   = 0;
      count_sum  = 0;
      pend_cnt_q.delete();
      rd_exp_q.delete();
      wr_addr_q.delete();
      wr_data_q.delete();
    end else begin
      check_response();
      advance_model();
      track_request();
      if (mem_rd_i.valid) begin
        if (rd_exp_q.size() == 0) begin
          report_failure("memory read with no word left to copy");
        end else begin
          exp_addr = rd_exp_q.pop_front();
          if (mem_rd_i.addr !== exp_addr) begin
            report_mismatch("mem_rd_o.addr", mem_rd_i.addr, exp_addr);
          end
        end
      end
      if (mem_wr_i.valid) begin
        wr_count++;
        if (wr_addr_q.size() == 0) begin
          report_failure("memory write with no word left to copy");
        end else begin
          exp_addr = wr_addr_q.pop_front();
          exp_data = wr_data_q.pop_front();
          if (mem_wr_i.addr !== exp_addr) begin
            report_mismatch("mem_wr_o.addr", mem_wr_i.addr, exp_addr);
          end
          if (mem_wr_i.data !== exp_data) begin
            report_mismatch("mem_wr_o.data", mem_wr_i.data, exp_data);
          end
        end
      end
      if (final_i && !final_done) begin
        final_done = 1'b1;
        if (wr_count != count_sum) begin
          report_mismatch("total write count", data_t'(wr_count), data_t'(count_sum));
        end
      end
    end
  end

endmodule

// File: verification/dma_core_tb.sv
// ##########################################################################
// Testbench of the DMA copy engine
// Random jobs from a fixed seed, with NEXT_ID reads fired back to back
// so that some launches are refused; the memory model never stalls
// ##########################################################################

`timescale 1ns/1ns

module dma_core_tb;

  import dma_pkg::*;

  localparam data_t FillKey     = 32'hA5A5A5A5;
  localparam int    NumJobs     = 40;
  localparam int    RspTimeout  = 8;
  localparam int    IdleTimeout = 400;

  logic     clk;
  logic     rst;
  reg_req_t reg_req;
  reg_rsp_t reg_rsp;
  mem_rd_t  mem_rd;
  data_t    mem_rdata;
  mem_wr_t  mem_wr;
  logic     final_check;
  int       chk_errors;
  int       timeouts;
  int       seed;
  data_t    rd_data;

  dma_core UUT (
    .clk_i       ( clk       ),
    .rst_i       ( rst       ),
    .reg_req_i   ( reg_req   ),
    .reg_rsp_o   ( reg_rsp   ),
    .mem_rd_o    ( mem_rd    ),
    .mem_rdata_i ( mem_rdata ),
    .mem_wr_o    ( mem_wr    )
  );

  dma_core_checker #(
    .FillKey ( FillKey )
  ) i_checker (
    .clk_i     ( clk         ),
    .rst_i     ( rst         ),
    .reg_req_i ( reg_req     ),
    .reg_rsp_i ( reg_rsp     ),
    .mem_rd_i  ( mem_rd      ),
    .mem_wr_i  ( mem_wr      ),
    .final_i   ( final_check ),
    .errors_o  ( chk_errors  )
  );

  always #10 clk = ~clk;

  // Each memory word reads as its address XOR the fill key
  always @(posedge clk) begin
    logic  hit;
    addr_t addr;
    hit  = mem_rd.valid && !rst;
    addr = mem_rd.addr;
    #2;
    mem_rdata = hit ? (addr ^ FillKey) : '0;
  end

  task automatic reg_write(input reg_addr_t addr, input data_t data);
    reg_req.valid = 1'b1;
    reg_req.write = 1'b1;
    reg_req.addr  = addr;
    reg_req.wdata = data;
    @(posedge clk);
    #2;
    reg_req = '0;
  endtask

  task automatic reg_read(input reg_addr_t addr, output data_t data);
    int waited;
    reg_req.valid = 1'b1;
    reg_req.write = 1'b0;
    reg_req.addr  = addr;
    reg_req.wdata = '0;
    @(posedge clk);
    #2;
    reg_req = '0;
    waited  = 0;
    while (!reg_rsp.rvalid && waited < RspTimeout) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (!reg_rsp.rvalid) begin
      $display("Timeout at %0t ns, no read response for register %0d", $time, addr);
      timeouts++;
    end
    data = reg_rsp.rdata;
  endtask

  // Consecutive NEXT_ID reads, one per cycle
  task automatic launch_burst(input int n);
    reg_req.valid = 1'b1;
    reg_req.write = 1'b0;
    reg_req.addr  = RegNextId;
    reg_req.wdata = '0;
    repeat (n) begin
      @(posedge clk);
      #2;
    end
    reg_req = '0;
  endtask

  task automatic run_job();
    addr_t  src;
    addr_t  dst;
    count_t cnt;
    int     r;
    src = $random(seed);
    dst = $random(seed);
    r   = $random(seed);
    cnt = count_t'(unsigned'(r) % 13);
    reg_write(RegSrc, src);
    reg_write(RegDst, dst);
    reg_write(RegCount, data_t'(cnt));
    if (r[4]) begin
      reg_read(RegSrc, rd_data);
      reg_read(RegDst, rd_data);
      reg_read(RegCount, rd_data);
    end
    launch_burst(1 + int'(r[9:8]));
    // Idle gap lets the backend catch up now and then
    repeat (int'(r[14:10])) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic wait_idle();
    data_t st;
    int    polls;
    st    = data_t'(1);
    polls = 0;
    while (st[0] !== 1'b0 && polls < IdleTimeout && timeouts == 0) begin
      reg_read(RegStatus, st);
      polls++;
    end
    if (st[0] !== 1'b0) begin
      $display("Timeout at %0t ns, engine still busy after %0d status polls", $time, polls);
      timeouts++;
    end
  endtask

  initial begin
    seed        = 65;
    timeouts    = 0;
    clk         = 1'b0;
    rst         = 1'b1;
    reg_req     = '0;
    mem_rdata   = '0;
    final_check = 1'b0;
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;
    for (int j = 0; j < NumJobs && timeouts == 0; j++) begin
      run_job();
    end
    if (timeouts == 0) begin
      wait_idle();
    end
    if (timeouts == 0) begin
      reg_read(RegDoneId, rd_data);
    end
    final_check = 1'b1;
    repeat (2) @(posedge clk);
    #2;
    $display("Errors: %0d from the checker, %0d timeouts", chk_errors, timeouts);
    if (chk_errors == 0 && timeouts == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: sources.f
hdl/dma_pkg.sv
hdl/dma_reg_frontend.sv
hdl/dma_desc_fifo.sv
hdl/dma_copy_backend.sv
hdl/dma_core.sv
verification/dma_core_props.sv
verification/dma_core_checker.sv
verification/dma_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the DMA testbench with Verilator and run it.
# The run fails when the log holds the fail message, an error, or no pass message.
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG"
{ verilator --binary --timing --assert --top-module dma_core_tb -f sources.f \
  && ./obj_dir/Vdma_core_tb; } > "$LOG" 2>&1 || echo "build or run returned an error" >> "$LOG"
cat "$LOG"
grep -q "sim failed" "$LOG" && exit 1
grep -q "%Error" "$LOG" && exit 1
grep -q "sim passed" "$LOG" || exit 1
exit 0
